// ==== sim.f ====
hw/usb_pkg.sv
hw/ulpi_link.sv
hw/usb_rx_decoder.sv
hw/usb_tx_encoder.sv
hw/usb_in_buffer.sv
hw/usb_bulk_ep.sv
hw/ulpi_usb_device.sv
verification/ulpi_usb_device_sva.sv
verification/tb_ulpi_usb_device.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ulpi_usb_device -f sim.f -o simv &&
./obj_dir/simv | awk '{ print } /Regression passed/ { found = 1 } END { exit !found }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verification/tb_ulpi_usb_device.sv ====
`timescale 1ns/100ps
module tb_ulpi_usb_device;
  import usb_pkg::*;

  typedef usb_byte_t byte_q_t[$];

  logic        clock, areset_n;
  logic        dir, nxt, data_oe, stp, crc_err, out_ready;
  usb_byte_t   ulpi_din, ulpi_dout, s_tdata, m_tdata;
  line_state_t line_state;
  logic        s_tvalid, s_tready, s_tlast, m_tvalid, m_tlast, m_terror;

  usb_byte_t tx_q[$];      // bytes the device put on the bus
  usb_byte_t m_data_q[$];
  logic      m_last_q[$];
  logic      m_err_q[$];
  logic      stp_seen;
  int        crc_err_cnt, errors, test_errors, tests_run;

  ulpi_usb_device dut0 (
    .clock(clock), .areset_n(areset_n),
    .ulpi_dir_i(dir), .ulpi_nxt_i(nxt), .ulpi_data_i(ulpi_din),
    .ulpi_data_o(ulpi_dout), .ulpi_data_oe_o(data_oe), .ulpi_stp_o(stp),
    .line_state_o(line_state), .crc_err_o(crc_err),
    .s_axis_tvalid_i(s_tvalid), .s_axis_tready_o(s_tready),
    .s_axis_tlast_i(s_tlast), .s_axis_tdata_i(s_tdata),
    .m_axis_tvalid_o(m_tvalid), .m_axis_tlast_o(m_tlast),
    .m_axis_tdata_o(m_tdata), .m_axis_terror_o(m_terror),
    .out_ready_i(out_ready)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // several times the length of all tests together
  initial begin
    #20000;
    $display("watchdog expired, the tests did not finish in 20 us");
    $display("Regression failed");
    $finish;
  end

  // phy side monitor sampled mid cycle
  always @(negedge clock) begin
    if (data_oe && nxt && !stp && !dir) tx_q.push_back(ulpi_dout);
    if (stp) stp_seen = 1'b1;
    if (m_tvalid) begin
      m_data_q.push_back(m_tdata);
      m_last_q.push_back(m_tlast);
      m_err_q.push_back(m_terror);
    end
    if (crc_err) crc_err_cnt++;
  end

  task automatic check_byte(string name, usb_byte_t got, usb_byte_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %02h got %02h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_pid(string name, usb_pid_t got, usb_pid_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %01h got %01h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_state(string name, line_state_t got, line_state_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
      errors++;
    end
  endtask

  // usb crc5 over the 11 token bits lsb first and sent inverted
  function automatic logic [4:0] crc5_of(logic [10:0] f);
    logic [4:0] c;
    logic       fb;
    c = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb = c[0] ^ f[i];
      c  = c >> 1;
      if (fb) c = c ^ 5'b10100;  // x^5+x^2+1 reflected
    end
    return ~c;
  endfunction

  function automatic logic [15:0] crc16_of(byte_q_t d);
    logic [15:0] c;
    logic        fb;
    c = 16'hffff;
    foreach (d[n]) begin
      for (int i = 0; i < 8; i++) begin
        fb = c[0] ^ d[n][i];
        c  = c >> 1;
        if (fb) c = c ^ 16'ha001;  // x^16+x^15+x^2+1 reflected
      end
    end
    return ~c;
  endfunction

  function automatic byte_q_t single_byte(usb_byte_t b);
    byte_q_t q;
    q.push_back(b);
    return q;
  endfunction

  function automatic byte_q_t token_bytes(usb_pid_t pid, usb_addr_t addr, usb_endp_t endp);
    byte_q_t    q;
    logic [10:0] f;
    f = {endp, addr};
    q.push_back({~pid, pid});
    q.push_back(f[7:0]);
    q.push_back({crc5_of(f), f[10:8]});
    return q;
  endfunction

  // pid byte, payload, crc16 low then high
  function automatic byte_q_t data_bytes(usb_byte_t first, byte_q_t pay, logic corrupt);
    byte_q_t     q;
    logic [15:0] c;
    c = crc16_of(pay);
    q = pay;
    q.push_front(first);
    q.push_back(c[7:0] ^ {7'd0, corrupt});
    q.push_back(c[15:8]);
    return q;
  endfunction

  function automatic byte_q_t random_payload(int len);
    byte_q_t q;
    for (int i = 0; i < len; i++) q.push_back(usb_byte_t'($urandom));
    return q;
  endfunction

  // host packet, turnaround, bytes with nxt, closing rx cmd
  task automatic host_send(byte_q_t bytes);
    @(posedge clock);
    dir      <= 1'b1;
    nxt      <= 1'b0;
    ulpi_din <= 8'h00;
    @(posedge clock);
    foreach (bytes[i]) begin
      nxt      <= 1'b1;
      ulpi_din <= bytes[i];
      @(posedge clock);
    end
    nxt      <= 1'b0;
    ulpi_din <= 8'h01;  // line J with rx inactive
    @(posedge clock);
    dir      <= 1'b0;
    nxt      <= 1'b1;   // phy always ready for tx
    ulpi_din <= 8'h00;
    @(posedge clock);
  endtask

  task automatic send_rxcmd(usb_byte_t cmd);
    @(posedge clock);
    dir <= 1'b1;
    nxt <= 1'b0;
    @(posedge clock);
    ulpi_din <= cmd;
    @(posedge clock);
    dir      <= 1'b0;
    nxt      <= 1'b1;
    ulpi_din <= 8'h00;
  endtask

  task automatic clear_capture();
    tx_q.delete();
    m_data_q.delete();
    m_last_q.delete();
    m_err_q.delete();
    stp_seen = 1'b0;
  endtask

  task automatic expect_response(string what, byte_q_t exp);
    int wait_cnt;
    wait_cnt = 0;
    while (!stp_seen && wait_cnt < 300) begin
      @(posedge clock);
      wait_cnt++;
    end
    if (!stp_seen) begin
      $display("%s: the device sent no packet", what);
      errors++;
    end else if (tx_q.size() != exp.size()) begin
      $display("%s: device sent %0d bytes instead of %0d", what, tx_q.size(), exp.size());
      errors++;
    end else begin
      check_pid("ulpi_data_o pid", tx_q[0][3:0], exp[0][3:0]);
      foreach (exp[i]) check_byte($sformatf("ulpi_data_o[%0d]", i), tx_q[i], exp[i]);
    end
  endtask

  task automatic expect_silence(string what);
    repeat (20) @(posedge clock);
    if (tx_q.size() != 0 || stp_seen) begin
      $display("%s: device answered although it should stay silent", what);
      errors++;
    end
  endtask

  task automatic expect_stream(byte_q_t pay, logic err);
    if (m_data_q.size() != pay.size()) begin
      $display("receive stream gave %0d beats instead of %0d", m_data_q.size(), pay.size());
      errors++;
    end else begin
      foreach (pay[i]) begin
        check_byte("m_axis_tdata_o", m_data_q[i], pay[i]);
        check_bit("m_axis_tlast_o", m_last_q[i], i == pay.size() - 1);
        check_bit("m_axis_terror_o", m_err_q[i], err && i == pay.size() - 1);
      end
    end
  endtask

  task automatic load_stream(byte_q_t bytes);
    int guard;
    @(posedge clock);
    foreach (bytes[i]) begin
      s_tvalid <= 1'b1;
      s_tdata  <= bytes[i];
      s_tlast  <= i == bytes.size() - 1;
      guard = 0;
      @(negedge clock);
      while (!s_tready && guard < 100) begin
        @(negedge clock);
        guard++;
      end
      if (!s_tready) begin
        $display("send stream never became ready");
        errors++;
      end
      @(posedge clock);
    end
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (errors == test_errors) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  task automatic test_reset_line_state();
    @(negedge clock);
    check_bit("ulpi_stp_o", stp, 1'b0);
    check_bit("m_axis_tvalid_o", m_tvalid, 1'b0);
    send_rxcmd(8'h02);
    repeat (2) @(negedge clock);
    check_state("line_state_o", line_state, 2'd2);
    finish_test("reset_line_state");
  endtask

  task automatic test_out_data();
    byte_q_t pay, none;
    pay = random_payload(4);
    clear_capture();
    host_send(token_bytes(PID_OUT, DEV_ADDR, BULK_EP));
    host_send(data_bytes({~PID_DATA0, PID_DATA0}, pay, 1'b0));
    expect_response("OUT DATA0", single_byte({4'h4, PID_ACK}));
    expect_stream(pay, 1'b0);
    clear_capture();  // same packet again is a duplicate
    host_send(token_bytes(PID_OUT, DEV_ADDR, BULK_EP));
    host_send(data_bytes({~PID_DATA0, PID_DATA0}, pay, 1'b0));
    expect_response("duplicate DATA0", single_byte({4'h4, PID_ACK}));
    expect_stream(none, 1'b0);
    finish_test("out_data");
  endtask

  task automatic test_filter_errors();
    byte_q_t pay, none;
    int      err0;
    pay  = random_payload(3);
    err0 = crc_err_cnt;
    clear_capture();
    host_send(token_bytes(PID_OUT, DEV_ADDR, BULK_EP));
    host_send(data_bytes({~PID_DATA1, PID_DATA1}, pay, 1'b1));
    expect_silence("bad crc16");
    if (crc_err_cnt - err0 != 1) begin
      $display("crc_err_o pulsed %0d times instead of once", crc_err_cnt - err0);
      errors++;
    end
    expect_stream(pay, 1'b1);
    clear_capture();
    host_send(token_bytes(PID_IN, 7'd6, BULK_EP));  // someone else's address
    expect_silence("address 6");
    @(posedge clock);
    out_ready <= 1'b0;
    clear_capture();
    host_send(token_bytes(PID_OUT, DEV_ADDR, BULK_EP));
    host_send(data_bytes({~PID_DATA1, PID_DATA1}, pay, 1'b0));
    expect_response("OUT with sink busy", single_byte({4'h4, PID_NAK}));
    expect_stream(none, 1'b0);
    out_ready <= 1'b1;
    finish_test("filter_errors");
  endtask

  task automatic test_in_empty();
    clear_capture();
    host_send(token_bytes(PID_IN, DEV_ADDR, BULK_EP));
    expect_response("IN empty", single_byte({4'h4, PID_NAK}));
    finish_test("in_empty");
  endtask

  task automatic test_in_data();
    byte_q_t pay, pay2;
    pay  = random_payload(8);
    pay2 = random_payload(5);
    load_stream(pay);
    repeat (3) @(negedge clock);
    check_bit("s_axis_tready_o", s_tready, 1'b0);
    clear_capture();
    host_send(token_bytes(PID_IN, DEV_ADDR, BULK_EP));
    expect_response("IN DATA0", data_bytes({4'h4, PID_DATA0}, pay, 1'b0));
    repeat (2 * ACK_TIMEOUT + MAX_PKT) @(posedge clock);  // let the ack wait expire
    clear_capture();
    host_send(token_bytes(PID_IN, DEV_ADDR, BULK_EP));
    expect_response("IN replay", data_bytes({4'h4, PID_DATA0}, pay, 1'b0));
    host_send(single_byte({~PID_ACK, PID_ACK}));
    repeat (3) @(negedge clock);
    check_bit("s_axis_tready_o", s_tready, 1'b1);
    load_stream(pay2);
    clear_capture();
    host_send(token_bytes(PID_IN, DEV_ADDR, BULK_EP));
    expect_response("IN DATA1", data_bytes({4'h4, PID_DATA1}, pay2, 1'b0));
    finish_test("in_data");
  endtask

  initial begin
    void'($urandom(32'h29323ff0));
    areset_n    = 1'b0;
    dir         = 1'b0;
    nxt         = 1'b1;
    ulpi_din    = 8'h00;
    s_tvalid    = 1'b0;
    s_tlast     = 1'b0;
    s_tdata     = 8'h00;
    out_ready   = 1'b1;
    stp_seen    = 1'b0;
    crc_err_cnt = 0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    repeat (8) @(posedge clock);
    areset_n <= 1'b1;
    repeat (4) @(posedge clock);
    test_reset_line_state();
    test_out_data();
    test_filter_errors();
    test_in_empty();
    test_in_data();
    $display("summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verification/ulpi_usb_device_sva.sv ====
`timescale 1ns/100ps
module ulpi_usb_device_sva (
  input logic clock,
  input logic reset_i,
  input logic dir_i,
  input logic data_oe_i,
  input logic stp_i,
  input logic tready_i,
  input logic full_i
);

  // phy owns the bus while dir is high
  assert property (@(posedge clock) disable iff (reset_i) !(stp_i && dir_i))
    else $error("stp high while dir high");

  // link must not drive in the turnaround cycle
  assert property (@(posedge clock) disable iff (reset_i) $rose(dir_i) |-> !data_oe_i)
    else $error("data_oe high after dir rose");

  assert property (@(posedge clock) disable iff (reset_i) full_i |-> !tready_i)
    else $error("send stream ready while buffer full");

endmodule

bind ulpi_usb_device ulpi_usb_device_sva sva0 (
  .clock(clock),
  .reset_i(reset),
  .dir_i(ulpi_dir_i),
  .data_oe_i(ulpi_data_oe_o),
  .stp_i(ulpi_stp_o),
  .tready_i(s_axis_tready_o),
  .full_i(buf_full)
);

// ==== hw/ulpi_usb_device.sv ====
`timescale 1ns/100ps
module ulpi_usb_device (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 ulpi_dir_i,
  input  logic                 ulpi_nxt_i,
  input  usb_pkg::usb_byte_t   ulpi_data_i,
  output usb_pkg::usb_byte_t   ulpi_data_o,
  output logic                 ulpi_data_oe_o,
  output logic                 ulpi_stp_o,
  output usb_pkg::line_state_t line_state_o,
  output logic                 crc_err_o,
  input  logic                 s_axis_tvalid_i,
  output logic                 s_axis_tready_o,
  input  logic                 s_axis_tlast_i,
  input  usb_pkg::usb_byte_t   s_axis_tdata_i,
  output logic                 m_axis_tvalid_o,
  output logic                 m_axis_tlast_o,
  output usb_pkg::usb_byte_t   m_axis_tdata_o,
  output logic                 m_axis_terror_o,
  input  logic                 out_ready_i
);
  import usb_pkg::*;

  logic      reset;
  logic      rx_valid, rx_active, rx_end;
  usb_byte_t rx_data;
  logic      tx_valid, tx_ready, tx_last;
  usb_byte_t tx_data;
  logic      tok_valid, hsk_valid, data_start, pay_valid, data_end, data_ok;
  usb_pid_t  tok_pid, hsk_pid, data_pid, tx_pid;
  usb_addr_t tok_addr;
  usb_endp_t tok_endp;
  usb_byte_t pay_data, rd_data;
  logic      buf_full, rd_start, buf_release, tx_req;
  logic      rd_valid, rd_ready, rd_last;

  ulpi_link u_link (
    .clock(clock), .areset_n(areset_n),
    .dir_i(ulpi_dir_i), .nxt_i(ulpi_nxt_i), .data_i(ulpi_data_i),
    .data_o(ulpi_data_o), .data_oe_o(ulpi_data_oe_o), .stp_o(ulpi_stp_o),
    .reset_o(reset), .line_state_o(line_state_o),
    .rx_valid_o(rx_valid), .rx_active_o(rx_active), .rx_end_o(rx_end), .rx_data_o(rx_data),
    .tx_valid_i(tx_valid), .tx_last_i(tx_last), .tx_data_i(tx_data), .tx_ready_o(tx_ready)
  );

  usb_rx_decoder u_dec (
    .clock(clock), .reset_i(reset),
    .rx_valid_i(rx_valid), .rx_active_i(rx_active), .rx_end_i(rx_end), .rx_data_i(rx_data),
    .tok_valid_o(tok_valid), .tok_pid_o(tok_pid), .tok_addr_o(tok_addr), .tok_endp_o(tok_endp),
    .hsk_valid_o(hsk_valid), .hsk_pid_o(hsk_pid),
    .data_start_o(data_start), .data_pid_o(data_pid),
    .pay_valid_o(pay_valid), .pay_data_o(pay_data),
    .data_end_o(data_end), .data_ok_o(data_ok), .crc_err_o(crc_err_o)
  );

  usb_bulk_ep u_ep (
    .clock(clock), .reset_i(reset),
    .tok_valid_i(tok_valid), .tok_pid_i(tok_pid), .tok_addr_i(tok_addr), .tok_endp_i(tok_endp),
    .hsk_valid_i(hsk_valid), .hsk_pid_i(hsk_pid),
    .data_start_i(data_start), .data_pid_i(data_pid),
    .pay_valid_i(pay_valid), .pay_data_i(pay_data),
    .data_end_i(data_end), .data_ok_i(data_ok),
    .out_ready_i(out_ready_i), .full_i(buf_full),
    .rd_start_o(rd_start), .release_o(buf_release), .tx_req_o(tx_req), .tx_pid_o(tx_pid),
    .m_axis_tvalid_o(m_axis_tvalid_o), .m_axis_tlast_o(m_axis_tlast_o),
    .m_axis_terror_o(m_axis_terror_o), .m_axis_tdata_o(m_axis_tdata_o)
  );

  usb_in_buffer u_buf (
    .clock(clock), .reset_i(reset),
    .s_axis_tvalid_i(s_axis_tvalid_i), .s_axis_tlast_i(s_axis_tlast_i),
    .s_axis_tdata_i(s_axis_tdata_i), .s_axis_tready_o(s_axis_tready_o),
    .full_o(buf_full), .rd_start_i(rd_start), .release_i(buf_release),
    .rd_valid_o(rd_valid), .rd_last_o(rd_last), .rd_data_o(rd_data), .rd_ready_i(rd_ready)
  );

  usb_tx_encoder u_enc (
    .clock(clock), .reset_i(reset), .tx_req_i(tx_req), .tx_pid_i(tx_pid),
    .rd_valid_i(rd_valid), .rd_last_i(rd_last), .rd_data_i(rd_data), .rd_ready_o(rd_ready),
    .tx_valid_o(tx_valid), .tx_last_o(tx_last), .tx_data_o(tx_data), .tx_ready_i(tx_ready)
  );

endmodule

// ==== hw/usb_bulk_ep.sv ====
`timescale 1ns/100ps
module usb_bulk_ep (
  input  logic               clock,
  input  logic               reset_i,
  input  logic               tok_valid_i,
  input  usb_pkg::usb_pid_t  tok_pid_i,
  input  usb_pkg::usb_addr_t tok_addr_i,
  input  usb_pkg::usb_endp_t tok_endp_i,
  input  logic               hsk_valid_i,
  input  usb_pkg::usb_pid_t  hsk_pid_i,
  input  logic               data_start_i,
  input  usb_pkg::usb_pid_t  data_pid_i,
  input  logic               pay_valid_i,
  input  usb_pkg::usb_byte_t pay_data_i,
  input  logic               data_end_i,
  input  logic               data_ok_i,
  input  logic               out_ready_i,
  input  logic               full_i,
  output logic               rd_start_o,
  output logic               release_o,
  output logic               tx_req_o,
  output usb_pkg::usb_pid_t  tx_pid_o,
  output logic               m_axis_tvalid_o,
  output logic               m_axis_tlast_o,
  output logic               m_axis_terror_o,
  output usb_pkg::usb_byte_t m_axis_tdata_o
);
  import usb_pkg::*;

  ep_state_e state;
  logic      out_tog, in_tog;
  logic      nak_q;   // sink was busy at the OUT token
  logic      fwd_q;   // right toggle and sink ready
  logic [7:0] ack_tmr;
  logic      tok_hit, rx_open, hold_v;
  usb_byte_t hold_d;  // last byte waits for data_end

  assign tok_hit = tok_valid_i && tok_addr_i == DEV_ADDR && tok_endp_i == BULK_EP;
  assign rx_open = (state == EP_OUT) && fwd_q;

  always_ff @(posedge clock or posedge reset_i) begin
    if (reset_i) begin
      state      <= EP_IDLE;
      out_tog    <= 1'b0;
      in_tog     <= 1'b0;
      nak_q      <= 1'b0;
      fwd_q      <= 1'b0;
      ack_tmr    <= '0;
      tx_req_o   <= 1'b0;
      tx_pid_o   <= PID_NAK;
      rd_start_o <= 1'b0;
      release_o  <= 1'b0;
    end else begin
      tx_req_o   <= 1'b0;
      rd_start_o <= 1'b0;
      release_o  <= 1'b0;
      ack_tmr    <= ack_tmr + 8'd1;
      if (tok_valid_i) begin
        state <= EP_IDLE;  // other devices and pids ignored
        if (tok_hit && tok_pid_i == PID_OUT) begin
          state <= EP_OUT;
          nak_q <= ~out_ready_i;
          fwd_q <= 1'b0;
        end else if (tok_hit && tok_pid_i == PID_IN) begin
          tx_req_o <= 1'b1;
          if (full_i) begin
            tx_pid_o   <= in_tog ? PID_DATA1 : PID_DATA0;
            rd_start_o <= 1'b1;
            state      <= EP_WAIT_ACK;
            ack_tmr    <= '0;
          end else begin
            tx_pid_o <= PID_NAK;  // nothing loaded
          end
        end
      end else begin
        case (state)
          EP_OUT: begin
            if (data_start_i) fwd_q <= ~nak_q & (data_pid_i == (out_tog ? PID_DATA1 : PID_DATA0));
            if (data_end_i) begin
              state <= EP_IDLE;
              if (data_ok_i) begin  // bad crc, stay silent
                tx_req_o <= 1'b1;
                tx_pid_o <= nak_q ? PID_NAK : PID_ACK;  // duplicates are acked too
                out_tog  <= out_tog ^ fwd_q;
              end
            end
          end
          EP_WAIT_ACK: begin
            if (hsk_valid_i && hsk_pid_i == PID_ACK) begin
              release_o <= 1'b1;
              in_tog    <= ~in_tog;
              state     <= EP_IDLE;
            end else if (ack_tmr == 8'(MAX_PKT + ACK_TIMEOUT + 4)) begin
              state <= EP_IDLE;  // timer spans the outgoing packet too
            end
          end
          default: ;
        endcase
      end
    end
  end

  // receive stream, one byte behind so tlast lands on the final byte
  always_ff @(posedge clock or posedge reset_i) begin
    if (reset_i) begin
      hold_v          <= 1'b0;
      m_axis_tvalid_o <= 1'b0;
      m_axis_tlast_o  <= 1'b0;
      m_axis_terror_o <= 1'b0;
    end else begin
      m_axis_tvalid_o <= 1'b0;
      m_axis_tlast_o  <= 1'b0;
      m_axis_terror_o <= 1'b0;
      if (tok_valid_i) hold_v <= 1'b0;
      if (rx_open && pay_valid_i) begin
        hold_v          <= 1'b1;
        m_axis_tvalid_o <= hold_v;
      end
      if (rx_open && data_end_i) begin
        hold_v          <= 1'b0;
        m_axis_tvalid_o <= hold_v;
        m_axis_tlast_o  <= hold_v;
        m_axis_terror_o <= hold_v & ~data_ok_i;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_open && (pay_valid_i || data_end_i)) m_axis_tdata_o <= hold_d;
    if (rx_open && pay_valid_i) hold_d <= pay_data_i;
  end

endmodule

// ==== hw/usb_in_buffer.sv ====
`timescale 1ns/100ps
module usb_in_buffer (
  input  logic               clock,
  input  logic               reset_i,
  input  logic               s_axis_tvalid_i,
  input  logic               s_axis_tlast_i,
  input  usb_pkg::usb_byte_t s_axis_tdata_i,
  output logic               s_axis_tready_o,
  output logic               full_o,
  input  logic               rd_start_i,
  input  logic               release_i,
  output logic               rd_valid_o,
  output logic               rd_last_o,
  output usb_pkg::usb_byte_t rd_data_o,
  input  logic               rd_ready_i
);
  import usb_pkg::*;

  usb_byte_t mem [MAX_PKT];
  pkt_len_t  wr_cnt;  // stored length
  pkt_len_t  rd_cnt;
  logic      full_q, full_d, tready_q, rd_busy, wr;

  assign wr              = s_axis_tvalid_i & tready_q;
  assign s_axis_tready_o = tready_q;
  assign full_o          = full_q;

  always_comb begin
    full_d = full_q;
    if (wr && (s_axis_tlast_i || wr_cnt == pkt_len_t'(MAX_PKT - 1))) full_d = 1'b1;
    if (release_i) full_d = 1'b0;  // host acked
  end

  always_ff @(posedge clock or posedge reset_i) begin
    if (reset_i) begin
      wr_cnt   <= '0;
      rd_cnt   <= '0;
      full_q   <= 1'b0;
      tready_q <= 1'b0;
      rd_busy  <= 1'b0;
    end else begin
      full_q   <= full_d;
      tready_q <= ~full_d;  // rises one cycle after reset or release
      if (release_i) wr_cnt <= '0;
      else if (wr) wr_cnt <= wr_cnt + pkt_len_t'(1);
      if (rd_start_i) begin
        rd_busy <= full_q;  // replay from byte 0
        rd_cnt  <= '0;
      end else if (rd_valid_o && rd_ready_i) begin
        rd_cnt <= rd_cnt + pkt_len_t'(1);
        if (rd_last_o) rd_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr) mem[wr_cnt[$clog2(MAX_PKT)-1:0]] <= s_axis_tdata_i;
  end

  assign rd_valid_o = rd_busy;
  assign rd_last_o  = rd_cnt == wr_cnt - pkt_len_t'(1);
  assign rd_data_o  = mem[rd_cnt[$clog2(MAX_PKT)-1:0]];

endmodule

// ==== hw/usb_tx_encoder.sv ====
`timescale 1ns/100ps
module usb_tx_encoder (
  input  logic               clock,
  input  logic               reset_i,
  input  logic               tx_req_i,
  input  usb_pkg::usb_pid_t  tx_pid_i,
  input  logic               rd_valid_i,
  input  logic               rd_last_i,
  input  usb_pkg::usb_byte_t rd_data_i,
  output logic               rd_ready_o,
  output logic               tx_valid_o,
  output logic               tx_last_o,
  output usb_pkg::usb_byte_t tx_data_o,
  input  logic               tx_ready_i
);
  import usb_pkg::*;

  enc_state_e  state;
  usb_pid_t    pid_q;
  logic [15:0] crc_q;
  logic        is_data, beat;

  assign is_data    = pid_q[1:0] == 2'b11;  // DATA0 or DATA1
  assign beat       = tx_valid_o & tx_ready_i;
  assign rd_ready_o = (state == ENC_PAY) & tx_ready_i;

  always_comb begin
    tx_valid_o = 1'b1;
    tx_last_o  = 1'b0;
    case (state)
      ENC_CMD: begin
        tx_data_o = {4'h4, pid_q};  // ulpi TX CMD, transmit with pid
        tx_last_o = !is_data;       // handshake ends here
      end
      ENC_PAY: begin
        tx_valid_o = rd_valid_i;
        tx_data_o  = rd_data_i;
      end
      ENC_CRC_LO: tx_data_o = ~crc_q[7:0];
      ENC_CRC_HI: begin
        tx_data_o = ~crc_q[15:8];
        tx_last_o = 1'b1;
      end
      default: begin
        tx_valid_o = 1'b0;
        tx_data_o  = 8'h00;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset_i) begin
    if (reset_i) begin
      state <= ENC_IDLE;
      pid_q <= PID_NAK;
      crc_q <= '1;
    end else begin
      case (state)
        ENC_IDLE: begin
          if (tx_req_i) begin
            state <= ENC_CMD;
            pid_q <= tx_pid_i;
            crc_q <= '1;
          end
        end
        ENC_CMD: if (beat) state <= is_data ? ENC_PAY : ENC_IDLE;
        ENC_PAY: begin
          if (beat) begin
            crc_q <= crc16_byte(crc_q, rd_data_i);
            if (rd_last_i) state <= ENC_CRC_LO;
          end
        end
        ENC_CRC_LO: if (beat) state <= ENC_CRC_HI;
        default: if (beat) state <= ENC_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/usb_rx_decoder.sv ====
`timescale 1ns/100ps
module usb_rx_decoder (
  input  logic               clock,
  input  logic               reset_i,
  input  logic               rx_valid_i,
  input  logic               rx_active_i,
  input  logic               rx_end_i,
  input  usb_pkg::usb_byte_t rx_data_i,
  output logic               tok_valid_o,
  output usb_pkg::usb_pid_t  tok_pid_o,
  output usb_pkg::usb_addr_t tok_addr_o,
  output usb_pkg::usb_endp_t tok_endp_o,
  output logic               hsk_valid_o,
  output usb_pkg::usb_pid_t  hsk_pid_o,
  output logic               data_start_o,
  output usb_pkg::usb_pid_t  data_pid_o,
  output logic               pay_valid_o,
  output usb_pkg::usb_byte_t pay_data_o,
  output logic               data_end_o,
  output logic               data_ok_o,
  output logic               crc_err_o
);
  import usb_pkg::*;

  dec_state_e  state;
  usb_pid_t    pid_q;
  logic [15:0] tok_q;    // token bytes 1 and 2
  logic [1:0]  tok_cnt;  // saturates, long tokens fail
  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;
  usb_byte_t   dly_q [2];
  logic [1:0]  dly_cnt;
  logic        take, pid_ok, tok_ok;

  function automatic logic [4:0] crc5_byte(logic [4:0] crc, usb_byte_t d);
    logic [4:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ d[i]) ? ((c >> 1) ^ 5'h14) : (c >> 1);
    end
    return c;
  endfunction

  assign take   = rx_valid_i & rx_active_i;
  assign pid_ok = rx_data_i[7:4] == ~rx_data_i[3:0];
  assign tok_ok = (tok_cnt == 2'd2) && (crc5_q == CRC5_RESIDUAL);

  always_ff @(posedge clock or posedge reset_i) begin
    if (reset_i) begin
      state   <= DEC_IDLE;
      pid_q   <= '0;
      tok_cnt <= '0;
      dly_cnt <= '0;
      crc5_q  <= '1;
      crc16_q <= '1;
    end else if (rx_end_i) begin
      state <= DEC_IDLE;
    end else if (take) begin
      case (state)
        DEC_IDLE: begin
          pid_q   <= rx_data_i[3:0];
          tok_cnt <= '0;
          dly_cnt <= '0;
          crc5_q  <= '1;
          crc16_q <= '1;
          if (!pid_ok) state <= DEC_BAD;
          else if (rx_data_i[1:0] == 2'b01) state <= DEC_TOK;
          else if (rx_data_i[1:0] == 2'b11) state <= DEC_DATA;
          else if (rx_data_i[1:0] == 2'b10) state <= DEC_HSK;
          else state <= DEC_SKIP;  // special pids
        end
        DEC_TOK: begin
          crc5_q <= crc5_byte(crc5_q, rx_data_i);
          if (tok_cnt != 2'd3) tok_cnt <= tok_cnt + 2'd1;
        end
        DEC_DATA: begin
          crc16_q <= crc16_byte(crc16_q, rx_data_i);  // runs over the trailer too
          if (dly_cnt != 2'd2) dly_cnt <= dly_cnt + 2'd1;
        end
        default: ;
      endcase
    end
  end

  // token fields and the two byte holdback
  always_ff @(posedge clock) begin
    if (take && state == DEC_TOK) tok_q <= {rx_data_i, tok_q[15:8]};
    if (take && state == DEC_DATA) begin
      dly_q[1] <= dly_q[0];
      dly_q[0] <= rx_data_i;
    end
  end

  assign tok_valid_o  = rx_end_i && state == DEC_TOK && tok_ok;
  assign tok_pid_o    = pid_q;
  assign tok_addr_o   = tok_q[6:0];
  assign tok_endp_o   = tok_q[10:7];
  assign hsk_valid_o  = rx_end_i && state == DEC_HSK;
  assign hsk_pid_o    = pid_q;
  assign data_start_o = take && state == DEC_IDLE && pid_ok && rx_data_i[1:0] == 2'b11;
  assign data_pid_o   = rx_data_i[3:0];
  assign pay_valid_o  = take && state == DEC_DATA && dly_cnt == 2'd2;
  assign pay_data_o   = dly_q[1];  // oldest held byte
  assign data_end_o   = rx_end_i && state == DEC_DATA;
  assign data_ok_o    = (dly_cnt == 2'd2) && (crc16_q == CRC16_RESIDUAL);
  assign crc_err_o    = rx_end_i && (state == DEC_BAD || (state == DEC_TOK && !tok_ok) ||
                                     (state == DEC_DATA && !data_ok_o));

endmodule

// ==== hw/ulpi_link.sv ====
`timescale 1ns/100ps
module ulpi_link (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 dir_i,
  input  logic                 nxt_i,
  input  usb_pkg::usb_byte_t   data_i,
  output usb_pkg::usb_byte_t   data_o,
  output logic                 data_oe_o,
  output logic                 stp_o,
  output logic                 reset_o,
  output usb_pkg::line_state_t line_state_o,
  output logic                 rx_valid_o,
  output logic                 rx_active_o,
  output logic                 rx_end_o,
  output usb_pkg::usb_byte_t   rx_data_o,
  input  logic                 tx_valid_i,
  input  logic                 tx_last_i,
  input  usb_pkg::usb_byte_t   tx_data_i,
  output logic                 tx_ready_o
);
  import usb_pkg::*;

  logic [1:0]  rst_sync;
  logic        dir_q;     // dir one cycle ago, marks turnaround
  link_state_e state;

  // two flops, asserted at once, released on the second edge
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign reset_o = ~rst_sync[1];

  always_ff @(posedge clock or posedge reset_o) begin
    if (reset_o) begin
      dir_q        <= 1'b0;
      rx_valid_o   <= 1'b0;
      rx_active_o  <= 1'b0;
      rx_end_o     <= 1'b0;
      line_state_o <= '0;
    end else begin
      dir_q      <= dir_i;
      rx_valid_o <= 1'b0;
      rx_end_o   <= dir_q & ~dir_i;  // dir falling
      if (dir_i && dir_q) begin      // skip the turnaround cycle
        if (nxt_i) begin
          rx_valid_o  <= 1'b1;       // packet byte
          rx_active_o <= 1'b1;
        end else begin
          line_state_o <= data_i[1:0];  // rx cmd
          rx_active_o  <= data_i[4];
        end
      end else if (!dir_i) begin
        rx_active_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dir_i && dir_q && nxt_i) begin
      rx_data_o <= data_i;
    end
  end

  // transmit, the encoder holds its byte until nxt
  always_ff @(posedge clock or posedge reset_o) begin
    if (reset_o) begin
      state <= LS_IDLE;
    end else begin
      case (state)
        LS_IDLE: if (tx_valid_i && !dir_i && !dir_q) state <= LS_TX;
        LS_TX: begin
          if (dir_i) begin
            state <= LS_IDLE;  // phy took the bus, abort
          end else if (tx_ready_o && tx_valid_i && tx_last_i) begin
            state <= LS_STP;
          end
        end
        default: state <= LS_IDLE;  // stp is a single cycle
      endcase
    end
  end

  always_comb begin
    data_oe_o  = (state != LS_IDLE) && !dir_i;
    stp_o      = (state == LS_STP) && !dir_i;
    tx_ready_o = (state == LS_TX) && !dir_i && nxt_i;
    data_o     = (state == LS_TX) ? tx_data_i : 8'h00;  // zeros with stp
  end

endmodule

// ==== hw/usb_pkg.sv ====
package usb_pkg;

  typedef logic [7:0] usb_byte_t;    // one bus or packet byte
  typedef logic [3:0] usb_pid_t;     // pid without check nibble
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;
  typedef logic [1:0] line_state_t;  // from rx cmd bits 1:0
  typedef logic [6:0] pkt_len_t;     // 0..MAX_PKT

  localparam usb_pid_t PID_OUT   = 4'b0001;
  localparam usb_pid_t PID_IN    = 4'b1001;
  localparam usb_pid_t PID_DATA0 = 4'b0011;
  localparam usb_pid_t PID_DATA1 = 4'b1011;
  localparam usb_pid_t PID_ACK   = 4'b0010;
  localparam usb_pid_t PID_NAK   = 4'b1010;

  localparam usb_addr_t DEV_ADDR = 7'd5;  // fixed, no enumeration
  localparam usb_endp_t BULK_EP  = 4'd1;
  localparam int MAX_PKT     = 64;        // payload bytes
  localparam int ACK_TIMEOUT = 64;        // cycles after IN data

  // residuals of the lsb-first crc registers below
  localparam logic [4:0]  CRC5_RESIDUAL  = 5'b00110;
  localparam logic [15:0] CRC16_RESIDUAL = 16'hB001;

  typedef enum logic [1:0] {LS_IDLE, LS_TX, LS_STP} link_state_e;
  typedef enum logic [2:0] {DEC_IDLE, DEC_TOK, DEC_DATA, DEC_HSK, DEC_SKIP, DEC_BAD} dec_state_e;
  typedef enum logic [1:0] {EP_IDLE, EP_OUT, EP_WAIT_ACK} ep_state_e;
  typedef enum logic [2:0] {ENC_IDLE, ENC_CMD, ENC_PAY, ENC_CRC_LO, ENC_CRC_HI} enc_state_e;

  // crc16 x^16+x^15+x^2+1, one byte, bit 0 first as on the wire
  function automatic logic [15:0] crc16_byte(logic [15:0] crc, usb_byte_t d);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ d[i]) ? ((c >> 1) ^ 16'hA001) : (c >> 1);
    end
    return c;
  endfunction

endpackage
